//--- rtl/uart_rx_pkg.sv
package uart_rx_pkg;

	// Frame layout: start, 8 data bits, even parity, stop
	localparam int DATA_BITS = 8;
	localparam int FRAME_BITS = DATA_BITS + 3;

	// System clocks per UART bit
	localparam int CLOCKS_PER_BIT = 16;

	// Next start edge is accepted from the middle of the stop bit on
	localparam int HOLDOFF_CLOCKS = FRAME_BITS * CLOCKS_PER_BIT - CLOCKS_PER_BIT / 2;

	localparam int BUFFER_DEPTH = 4;

	// Derived widths
	localparam int HOLDOFF_WIDTH = $clog2(HOLDOFF_CLOCKS + 1);
	localparam int TIMER_WIDTH = $clog2(CLOCKS_PER_BIT);
	localparam int BIT_IDX_WIDTH = $clog2(DATA_BITS);
	localparam int BUFFER_PTR_WIDTH = $clog2(BUFFER_DEPTH);
	localparam int BUFFER_COUNT_WIDTH = $clog2(BUFFER_DEPTH + 1);

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_t;

	typedef struct packed {
		logic [DATA_BITS-1:0] data;
		logic parity_err;	// Data plus parity bit summed to odd
		logic frame_err;	// Stop bit sampled low
	} rx_word_t;

endpackage

//--- rtl/rx_start_detect.sv
`timescale 1ns/1ns

module rx_start_detect import uart_rx_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic serial_in,
	output logic serial_synced,
	output logic start_pulse
);

	logic sync_meta;
	logic prev_synced;
	logic [HOLDOFF_WIDTH-1:0] holdoff_cnt;
	logic falling_edge;
	logic holdoff_done;

	// Two flop synchronizer, line idles high
	always_ff @(posedge clk) begin
		if (reset) begin
			sync_meta <= 1'b1;
			serial_synced <= 1'b1;
			prev_synced <= 1'b1;
		end else begin
			sync_meta <= serial_in;
			serial_synced <= sync_meta;
			prev_synced <= serial_synced;
		end
	end

	assign falling_edge = prev_synced && !serial_synced;
	assign holdoff_done = (holdoff_cnt == HOLDOFF_WIDTH'(HOLDOFF_CLOCKS));

	// Edges inside a running frame are masked by the hold-off count.
	// The counter comes out of reset saturated so the first edge is taken.
	always_ff @(posedge clk) begin
		if (reset) begin
			start_pulse <= 1'b0;
			holdoff_cnt <= HOLDOFF_WIDTH'(HOLDOFF_CLOCKS);
		end else begin
			start_pulse <= 1'b0;
			if (falling_edge && holdoff_done) begin
				start_pulse <= 1'b1;
				holdoff_cnt <= '0;
			end else if (!holdoff_done) begin
				holdoff_cnt <= holdoff_cnt + 1'b1;	// Saturates at HOLDOFF_CLOCKS
			end
		end
	end

endmodule

//--- rtl/rx_bit_timer.sv
`timescale 1ns/1ns

module rx_bit_timer import uart_rx_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic restart,
	output logic sample_tick
);

	localparam logic [TIMER_WIDTH-1:0] HALF_BIT_LOAD = TIMER_WIDTH'(CLOCKS_PER_BIT / 2 - 1);
	localparam logic [TIMER_WIDTH-1:0] FULL_BIT_LOAD = TIMER_WIDTH'(CLOCKS_PER_BIT - 1);

	logic [TIMER_WIDTH-1:0] count;

	// Down counter. A restart lands the first tick in the middle of the
	// start bit, every later tick is one full bit further on.
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= FULL_BIT_LOAD;
			sample_tick <= 1'b0;
		end else if (restart) begin
			count <= HALF_BIT_LOAD;
			sample_tick <= 1'b0;
		end else if (count == '0) begin
			count <= FULL_BIT_LOAD;
			sample_tick <= 1'b1;
		end else begin
			count <= count - 1'b1;
			sample_tick <= 1'b0;
		end
	end

endmodule

//--- rtl/rx_frame_fsm.sv
`timescale 1ns/1ns

module rx_frame_fsm import uart_rx_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic start_pulse,
	input  logic sample_tick,
	input  logic serial_synced,
	output logic timer_restart,
	output logic shift_en,
	output logic check_stop,
	output logic frame_clear
);

	rx_state_t state;
	rx_state_t state_next;
	logic [BIT_IDX_WIDTH-1:0] bit_idx;
	logic last_data_bit;

	assign last_data_bit = (bit_idx == BIT_IDX_WIDTH'(DATA_BITS - 1));

	always_comb begin
		state_next = state;
		timer_restart = 1'b0;
		shift_en = 1'b0;
		check_stop = 1'b0;
		frame_clear = 1'b0;
		case (state)
			RX_IDLE: begin
				if (start_pulse) begin
					timer_restart = 1'b1;
					state_next = RX_START;
				end
			end
			RX_START: begin
				if (sample_tick) begin
					if (serial_synced) begin
						state_next = RX_IDLE;	// Line back high, glitch only
					end else begin
						frame_clear = 1'b1;
						state_next = RX_DATA;
					end
				end
			end
			RX_DATA: begin
				if (sample_tick) begin
					shift_en = 1'b1;
					if (last_data_bit)
						state_next = RX_PARITY;
				end
			end
			RX_PARITY: begin
				if (sample_tick) begin
					shift_en = 1'b1;	// Parity bit goes through the shifter too
					state_next = RX_STOP;
				end
			end
			RX_STOP: begin
				if (sample_tick) begin
					check_stop = 1'b1;
					state_next = RX_IDLE;
				end
			end
			default: state_next = RX_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= RX_IDLE;
			bit_idx <= '0;
		end else begin
			state <= state_next;
			if (frame_clear)
				bit_idx <= '0;
			else if (state == RX_DATA && sample_tick)
				bit_idx <= bit_idx + 1'b1;
		end
	end

endmodule

//--- rtl/rx_shift_check.sv
`timescale 1ns/1ns

module rx_shift_check import uart_rx_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic serial_synced,
	input  logic shift_en,
	input  logic check_stop,
	input  logic frame_clear,
	output logic word_valid,
	output rx_word_t word
);

	// Data and parity bits enter at the top and move down, so after the
	// parity shift the low byte holds the data LSB first
	logic [DATA_BITS:0] shift_reg;
	logic parity_acc;

	always_ff @(posedge clk) begin
		if (shift_en)
			shift_reg <= {serial_synced, shift_reg[DATA_BITS:1]};
	end

	// Running XOR over data and parity, even parity leaves it at zero
	always_ff @(posedge clk) begin
		if (reset)
			parity_acc <= 1'b0;
		else if (frame_clear)
			parity_acc <= 1'b0;
		else if (shift_en)
			parity_acc <= parity_acc ^ serial_synced;
	end

	// Word is captured at the stop bit sample
	always_ff @(posedge clk) begin
		if (check_stop) begin
			word.data <= shift_reg[DATA_BITS-1:0];
			word.parity_err <= parity_acc;
			word.frame_err <= !serial_synced;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			word_valid <= 1'b0;
		else
			word_valid <= check_stop;	// One cycle strobe per frame
	end

endmodule

//--- rtl/rx_word_buffer.sv
`timescale 1ns/1ns

module rx_word_buffer import uart_rx_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic word_valid,
	input  rx_word_t word,
	input  logic out_ready,
	output logic out_valid,
	output rx_word_t out_word,
	output logic overrun
);

	rx_word_t mem [BUFFER_DEPTH];
	logic [BUFFER_PTR_WIDTH-1:0] wr_ptr;
	logic [BUFFER_PTR_WIDTH-1:0] rd_ptr;
	logic [BUFFER_COUNT_WIDTH-1:0] count;
	logic full;
	logic push;
	logic pop;

	assign full = (count == BUFFER_COUNT_WIDTH'(BUFFER_DEPTH));
	assign push = word_valid && !full;	// No room frees up for a word arriving while full
	assign pop = out_valid && out_ready;

	assign out_valid = (count != '0);
	assign out_word = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= word;
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overrun <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			if (word_valid && full)
				overrun <= 1'b1;	// Sticky until reset
		end
	end

endmodule

//--- rtl/uart_rx_top.sv
`timescale 1ns/1ns

module uart_rx_top import uart_rx_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic serial_in,
	input  logic out_ready,
	output logic out_valid,
	output rx_word_t out_word,
	output logic overrun
);

	logic serial_synced;
	logic start_pulse;
	logic timer_restart;
	logic sample_tick;
	logic shift_en;
	logic check_stop;
	logic frame_clear;
	logic word_valid;
	rx_word_t word;

	rx_start_detect i_rx_start_detect (
		.clk           (clk),
		.reset         (reset),
		.serial_in     (serial_in),
		.serial_synced (serial_synced),
		.start_pulse   (start_pulse)
	);

	rx_bit_timer i_rx_bit_timer (
		.clk         (clk),
		.reset       (reset),
		.restart     (timer_restart),
		.sample_tick (sample_tick)
	);

	rx_frame_fsm i_rx_frame_fsm (
		.clk           (clk),
		.reset         (reset),
		.start_pulse   (start_pulse),
		.sample_tick   (sample_tick),
		.serial_synced (serial_synced),
		.timer_restart (timer_restart),
		.shift_en      (shift_en),
		.check_stop    (check_stop),
		.frame_clear   (frame_clear)
	);

	rx_shift_check i_rx_shift_check (
		.clk           (clk),
		.reset         (reset),
		.serial_synced (serial_synced),
		.shift_en      (shift_en),
		.check_stop    (check_stop),
		.frame_clear   (frame_clear),
		.word_valid    (word_valid),
		.word          (word)
	);

	rx_word_buffer i_rx_word_buffer (
		.clk        (clk),
		.reset      (reset),
		.word_valid (word_valid),
		.word       (word),
		.out_ready  (out_ready),
		.out_valid  (out_valid),
		.out_word   (out_word),
		.overrun    (overrun)
	);

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic reset
);

	localparam int HALF_PERIOD = 50;	// 100 ns clock
	localparam int RESET_CYCLES = 16;
	localparam int RELEASE_DELAY = 10;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#RELEASE_DELAY reset = 1'b0;	// Released off the edge like other inputs
	end

endmodule

//--- tb/uart_rx_checker.sv
`timescale 1ns/1ns

module uart_rx_checker import uart_rx_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic out_valid,
	input  logic out_ready,
	input  rx_word_t out_word,
	input  logic overrun,
	input  logic start_pulse
);

	int failure_count = 0;	// Read by the testbench top

	// Stalled output word must not move
	assert property (@(posedge clk) disable iff (reset)
		(out_valid && !out_ready) |=> $stable(out_word))
		else begin
			failure_count++;
			$error("out_word changed while out_valid was high and out_ready low");
		end

	assert property (@(posedge clk) disable iff (reset) start_pulse |=> !start_pulse)
		else begin
			failure_count++;
			$error("start_pulse was high for two cycles in a row");
		end

	// Overrun is sticky
	assert property (@(posedge clk) disable iff (reset) !$fell(overrun))
		else begin
			failure_count++;
			$error("overrun fell outside reset");
		end

endmodule

bind uart_rx_top uart_rx_checker i_uart_rx_checker (
	.clk         (clk),
	.reset       (reset),
	.out_valid   (out_valid),
	.out_ready   (out_ready),
	.out_word    (out_word),
	.overrun     (overrun),
	.start_pulse (start_pulse)
);

//--- tb/uart_rx_monitor.sv
`timescale 1ns/1ns

module uart_rx_monitor import uart_rx_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic out_valid,
	input  logic out_ready,
	input  rx_word_t out_word
);

	rx_word_t expected_q [$];	// Reference model, in send order
	string name_q [$];	// Test that queued each word
	int error_count = 0;
	int word_count = 0;

	task automatic expect_word(input string test_name, input rx_word_t w);
		expected_q.push_back(w);
		name_q.push_back(test_name);
	endtask

	function automatic int pending();
		return expected_q.size();
	endfunction

	task automatic compare_flag(input string test_name, input string what, input logic expected,
			input logic actual);
		if (actual !== expected) begin
			$display("mismatch test=%s %s expected=%b actual=%b", test_name, what, expected,
				actual);
			error_count++;
		end
	endtask

	// Every handshake pops one expected word
	always @(posedge clk) begin : watch_handshake
		rx_word_t exp_word;
		string exp_name;
		if (!reset && out_valid && out_ready) begin
			word_count++;
			if (expected_q.size() == 0) begin
				$display("error: DUT delivered word %h while no word was expected", out_word);
				error_count++;
			end else begin
				exp_word = expected_q.pop_front();
				exp_name = name_q.pop_front();
				if (out_word !== exp_word) begin
					$display("mismatch test=%s expected=%h actual=%h", exp_name, exp_word,
						out_word);
					error_count++;
				end
			end
		end
	end

endmodule

//--- tb/uart_rx_tb.sv
`timescale 1ns/1ns

module uart_rx_tb import uart_rx_pkg::*; ();

	localparam int DRIVE_DELAY = 10;
	localparam int FRAME_CLOCKS = FRAME_BITS * CLOCKS_PER_BIT;
	localparam int RESET_TIMEOUT = 100;
	localparam int DRAIN_TIMEOUT = 50 * FRAME_CLOCKS;
	localparam int RANDOM_FRAMES = 40;

	logic clk;
	logic reset;
	logic serial_in;
	logic out_ready;
	logic out_valid;
	rx_word_t out_word;
	logic overrun;

	logic random_ready;	// Random out_ready on every cycle while frames go out
	int tests_run;
	int tests_failed;
	int errors_before;
	int timeouts;

	tb_clock i_tb_clock (
		.clk   (clk),
		.reset (reset)
	);

	uart_rx_top i_uart_rx_top (
		.clk       (clk),
		.reset     (reset),
		.serial_in (serial_in),
		.out_ready (out_ready),
		.out_valid (out_valid),
		.out_word  (out_word),
		.overrun   (overrun)
	);

	uart_rx_monitor i_uart_rx_monitor (
		.clk       (clk),
		.reset     (reset),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_word  (out_word)
	);

	function automatic int total_errors();
		return i_uart_rx_monitor.error_count + i_uart_rx_top.i_uart_rx_checker.failure_count
			+ timeouts;
	endfunction

	// Expected word from the even parity rule and the stop bit level
	function automatic rx_word_t expected_word(input logic [7:0] data, input logic parity_bit,
			input logic stop_bit);
		rx_word_t w;
		w.data = data;
		w.parity_err = ^{data, parity_bit};
		w.frame_err = !stop_bit;
		return w;
	endfunction

	task automatic hold_line(input logic level, input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#DRIVE_DELAY;
			serial_in = level;
			if (random_ready)
				out_ready = 1'($urandom_range(0, 1));
		end
	endtask

	task automatic set_ready(input logic level);
		@(posedge clk);
		#DRIVE_DELAY;
		out_ready = level;
	endtask

	// Start bit, data LSB first, parity, stop
	task automatic send_frame(input logic [7:0] data, input logic parity_bit,
			input logic stop_bit);
		hold_line(1'b0, CLOCKS_PER_BIT);
		for (int i = 0; i < DATA_BITS; i++)
			hold_line(data[i], CLOCKS_PER_BIT);
		hold_line(parity_bit, CLOCKS_PER_BIT);
		hold_line(stop_bit, CLOCKS_PER_BIT);
		if (!stop_bit)
			hold_line(1'b1, CLOCKS_PER_BIT);	// Line must go high again for the next start edge
	endtask

	task automatic wait_for_drain(input string test_name);
		int cycles;
		cycles = 0;
		while (i_uart_rx_monitor.pending() != 0 && cycles < DRAIN_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (i_uart_rx_monitor.pending() != 0) begin
			$display("timeout in %s: %0d expected words were never delivered", test_name,
				i_uart_rx_monitor.pending());
			timeouts++;
		end
	endtask

	task automatic begin_test();
		errors_before = total_errors();
	endtask

	task automatic end_test(input string test_name);
		int new_errors;
		new_errors = total_errors() - errors_before;
		tests_run++;
		if (new_errors == 0) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, new_errors);
		end
	endtask

	// Stops after the first test whose words never arrive
	task automatic run_test_sequence();
		logic [7:0] data;
		logic parity_bit;
		logic stop_bit;

		// Idle line produces nothing
		begin_test();
		set_ready(1'b1);
		i_uart_rx_monitor.compare_flag("idle_after_reset", "out_valid", 1'b0, out_valid);
		i_uart_rx_monitor.compare_flag("idle_after_reset", "overrun", 1'b0, overrun);
		hold_line(1'b1, 3 * FRAME_CLOCKS);
		i_uart_rx_monitor.compare_flag("idle_after_reset", "out_valid", 1'b0, out_valid);
		i_uart_rx_monitor.compare_flag("idle_after_reset", "overrun", 1'b0, overrun);
		end_test("idle_after_reset");

		// Back to back frames with random back-pressure
		begin_test();
		random_ready = 1'b1;
		for (int n = 0; n < RANDOM_FRAMES; n++) begin
			data = 8'($urandom_range(0, 255));
			parity_bit = ^data;
			i_uart_rx_monitor.expect_word("random_frames", expected_word(data, parity_bit, 1'b1));
			send_frame(data, parity_bit, 1'b1);
		end
		random_ready = 1'b0;
		set_ready(1'b1);
		wait_for_drain("random_frames");
		end_test("random_frames");
		if (timeouts != 0)
			return;

		// Bad parity, low stop bit, and both at once
		begin_test();
		for (int n = 0; n < 6; n++) begin
			data = 8'($urandom_range(0, 255));
			parity_bit = (n % 3 == 1) ? ^data : ~^data;
			stop_bit = (n % 3 == 0);
			i_uart_rx_monitor.expect_word("error_flags", expected_word(data, parity_bit, stop_bit));
			send_frame(data, parity_bit, stop_bit);
		end
		wait_for_drain("error_flags");
		end_test("error_flags");
		if (timeouts != 0)
			return;

		// Six frames into a four entry buffer
		begin_test();
		i_uart_rx_monitor.compare_flag("overrun", "overrun", 1'b0, overrun);
		set_ready(1'b0);
		for (int n = 0; n < 6; n++) begin
			data = 8'($urandom_range(0, 255));
			parity_bit = ^data;
			if (n < BUFFER_DEPTH)
				i_uart_rx_monitor.expect_word("overrun", expected_word(data, parity_bit, 1'b1));
			send_frame(data, parity_bit, 1'b1);
		end
		hold_line(1'b1, CLOCKS_PER_BIT);
		i_uart_rx_monitor.compare_flag("overrun", "out_valid", 1'b1, out_valid);
		i_uart_rx_monitor.compare_flag("overrun", "overrun", 1'b1, overrun);
		set_ready(1'b1);
		wait_for_drain("overrun");
		hold_line(1'b1, FRAME_CLOCKS);
		i_uart_rx_monitor.compare_flag("overrun", "out_valid", 1'b0, out_valid);
		i_uart_rx_monitor.compare_flag("overrun", "overrun", 1'b1, overrun);
		end_test("overrun");
		if (timeouts != 0)
			return;

		// Short low glitch, then a real frame once the hold-off has run out
		begin_test();
		hold_line(1'b0, CLOCKS_PER_BIT / 4 - 1);
		hold_line(1'b1, 2 * FRAME_CLOCKS);
		i_uart_rx_monitor.compare_flag("start_glitch", "out_valid", 1'b0, out_valid);
		data = 8'($urandom_range(0, 255));
		parity_bit = ^data;
		i_uart_rx_monitor.expect_word("start_glitch", expected_word(data, parity_bit, 1'b1));
		send_frame(data, parity_bit, 1'b1);
		wait_for_drain("start_glitch");
		end_test("start_glitch");
	endtask

	initial begin
		int cycles;

		serial_in = 1'b1;
		out_ready = 1'b0;
		random_ready = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		errors_before = 0;
		timeouts = 0;
		void'($urandom(19));

		cycles = 0;
		while (reset !== 1'b0 && cycles < RESET_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (reset !== 1'b0) begin
			$display("reset was never released");
			timeouts++;
		end else begin
			run_test_sequence();
		end

		$display("tests %0d, passed %0d, failed %0d, errors %0d, words %0d",
			tests_run, tests_run - tests_failed, tests_failed, total_errors(),
			i_uart_rx_monitor.word_count);
		if (tests_failed == 0 && total_errors() == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- tb.f
rtl/uart_rx_pkg.sv
rtl/rx_start_detect.sv
rtl/rx_bit_timer.sv
rtl/rx_frame_fsm.sv
rtl/rx_shift_check.sv
rtl/rx_word_buffer.sv
rtl/uart_rx_top.sv
tb/tb_clock.sv
tb/uart_rx_checker.sv
tb/uart_rx_monitor.sv
tb/uart_rx_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= uart_rx_tb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert
SIM_ARGS ?= +verilator+error+limit+100
PASS_TEXT ?= Regression passed

SOURCES := $(wildcard rtl/*.sv tb/*.sv)
SIM_EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

$(SIM_EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_EXE)
	@out="$$($(SIM_EXE) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
